/* all.f */
hw/crypto_ahb_pkg.sv
hw/ahb_wr_if.sv
hw/crypto_job_if.sv
hw/ahb_addr_decode.sv
hw/reg_write_exec.sv
hw/job_buffer.sv
hw/crypto_ahb_slave.sv
sim/crypto_ahb_asserts.sv
sim/ahb_checker.sv
sim/tb_crypto_ahb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the crypto AHB slave testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module tb_crypto_ahb \
  -f all.f \
  -o tb_crypto_ahb

./obj_dir/tb_crypto_ahb +verilator+error+limit+100 | tee sim.log

if grep -qx "=== PASS ===" sim.log
then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* sim/tb_crypto_ahb.sv */
`timescale 1ns/1ps

module tb_crypto_ahb;

  localparam logic [31:0] BASE_ADDR = 32'h4000_0000;
  // 75 planned transfers over all tests
  localparam int         LIMIT      = 75 * 40 + 200;
  localparam logic [1:0] RDY_RANDOM = 2'd0;
  localparam logic [1:0] RDY_LOW    = 2'd1;
  localparam logic [1:0] RDY_HIGH   = 2'd2;
  localparam logic [2:0] WORD       = crypto_ahb_pkg::HSIZE_WORD;

  typedef struct packed {
    logic [31:0] addr;
    logic [1:0]  trans;
    logic [2:0]  burst;
    logic        write;
    logic [2:0]  size;
    logic [31:0] data;
  } xfer_t;

  logic         HCLK;
  logic         HRESETn;
  logic         HSEL;
  logic         HWRITE;
  logic         HREADYOUT;
  logic         HRESP;
  logic [31:0]  HADDR;
  logic [31:0]  HWDATA;
  logic [2:0]   HSIZE;
  logic [2:0]   HBURST;
  logic [1:0]   HTRANS;
  logic         job_valid;
  logic         job_ready = 1'b0;
  logic [127:0] job_key;
  logic [127:0] job_nonce;
  logic [127:0] job_dest;
  logic [127:0] job_plain_text;
  logic [2:0]   test_id;
  logic [1:0]   rdy_mode = RDY_RANDOM;
  logic [31:0]  rdy_rnd;
  int           errors;
  int           jobs_seen;
  int           pending;
  int           cycles;
  xfer_t        seq_q [$];

  // Single slave, so HREADY is its own HREADYOUT
  crypto_ahb_slave #(.BASE_ADDR(BASE_ADDR)) dut (.HREADY(HREADYOUT), .*);

  ahb_checker #(.BASE_ADDR(BASE_ADDR)) u_checker (.*);

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  initial
  begin
    cycles = 0;
    while (cycles < LIMIT)
    begin
      @(posedge HCLK);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  always @(posedge HCLK)
  begin
    rdy_rnd = $urandom;
    if (rdy_mode == RDY_RANDOM)
      job_ready <= rdy_rnd[0];
    else
      job_ready <= (rdy_mode == RDY_HIGH);
  end

  task automatic add_xfer(input logic [31:0] addr, input logic [1:0] trans,
                          input logic [2:0] burst, input logic write,
                          input logic [2:0] size, input logic [31:0] data);
    seq_q.push_back({addr, trans, burst, write, size, data});
  endtask

  task automatic queue_write(input int idx, input logic [31:0] data);
    add_xfer(BASE_ADDR + 32'(idx * 4), crypto_ahb_pkg::NONSEQ, crypto_ahb_pkg::SINGLE,
             1'b1, WORD, data);
  endtask

  task automatic queue_burst(input int field);
    for (int w = 0; w < 4; w++)
      add_xfer(BASE_ADDR + 32'(field * 16 + w * 4),
               (w == 0) ? crypto_ahb_pkg::NONSEQ : crypto_ahb_pkg::SEQ,
               crypto_ahb_pkg::INCR4, 1'b1, WORD, $urandom);
  endtask

  // All 16 words in random order, last plain-text word at the end
  task automatic queue_full_job();
    int order [15];
    int j;
    int tmp;
    for (int k = 0; k < 15; k++)
      order[k] = k;
    for (int k = 14; k > 0; k--)
    begin
      j        = int'($urandom_range(k, 0));
      tmp      = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < 15; k++)
      queue_write(order[k], $urandom);
    queue_write(15, $urandom);
  endtask

  task automatic drive_addr(input xfer_t x);
    HSEL   <= 1'b1;
    HADDR  <= x.addr;
    HTRANS <= x.trans;
    HBURST <= x.burst;
    HWRITE <= x.write;
    HSIZE  <= x.size;
  endtask

  // Pipelined address and data phases, stalled by HREADYOUT
  task automatic run_seq();
    int i;
    i = 0;
    @(posedge HCLK);
    drive_addr(seq_q[0]);
    while (i < seq_q.size())
    begin
      @(posedge HCLK);
      if (HREADYOUT)
      begin
        HWDATA <= seq_q[i].data;
        i++;
        if (i < seq_q.size())
          drive_addr(seq_q[i]);
        else
        begin
          HSEL   <= 1'b0;
          HTRANS <= crypto_ahb_pkg::IDLE;
        end
      end
    end
    @(posedge HCLK);
    while (!HREADYOUT)
      @(posedge HCLK);
    seq_q.delete();
  endtask

  task automatic drain_jobs();
    @(posedge HCLK);
    while ((pending != 0) || job_valid)
      @(posedge HCLK);
  endtask

  initial
  begin
    void'($urandom(32'hf9f0_af79));
    HRESETn = 1'b0;
    HSEL    = 1'b0;
    HADDR   = '0;
    HWRITE  = 1'b0;
    HSIZE   = WORD;
    HBURST  = crypto_ahb_pkg::SINGLE;
    HTRANS  = crypto_ahb_pkg::IDLE;
    HWDATA  = '0;
    test_id = 3'd0;
    repeat (8) @(posedge HCLK);
    HRESETn <= 1'b1;

    test_id <= 3'd1;
    queue_full_job();
    run_seq();
    drain_jobs();

    test_id <= 3'd2;
    for (int f = 0; f < 4; f++)
      queue_burst(f);
    run_seq();
    drain_jobs();

    // Unmapped, read, halfword, BUSY in SINGLE, lone SEQ
    test_id <= 3'd3;
    add_xfer(BASE_ADDR + 32'h40, crypto_ahb_pkg::NONSEQ, crypto_ahb_pkg::SINGLE, 1'b1, WORD,
             $urandom);
    run_seq();
    add_xfer(BASE_ADDR, crypto_ahb_pkg::NONSEQ, crypto_ahb_pkg::SINGLE, 1'b0, WORD, '0);
    run_seq();
    add_xfer(BASE_ADDR + 32'h04, crypto_ahb_pkg::NONSEQ, crypto_ahb_pkg::SINGLE, 1'b1, 3'b001,
             $urandom);
    run_seq();
    add_xfer(BASE_ADDR + 32'h10, crypto_ahb_pkg::BUSY, crypto_ahb_pkg::SINGLE, 1'b1, WORD,
             $urandom);
    run_seq();
    add_xfer(BASE_ADDR + 32'h20, crypto_ahb_pkg::SEQ, crypto_ahb_pkg::INCR, 1'b1, WORD, $urandom);
    run_seq();
    queue_write(15, $urandom);
    run_seq();
    drain_jobs();

    // First job parks in the buffer, second one stalls behind it
    test_id  <= 3'd4;
    rdy_mode <= RDY_LOW;
    queue_full_job();
    run_seq();
    fork
      begin
        queue_full_job();
        run_seq();
      end
      begin
        @(posedge HCLK);
        while (HREADYOUT)
          @(posedge HCLK);
        repeat (5) @(posedge HCLK);
        rdy_mode <= RDY_HIGH;
      end
    join
    drain_jobs();

    test_id  <= 3'd5;
    rdy_mode <= RDY_RANDOM;
    queue_burst(1);
    queue_write(15, $urandom);
    run_seq();
    drain_jobs();

    repeat (3) @(posedge HCLK);
    $display("Checks done: %0d errors, %0d assertion failures, %0d jobs",
             errors, dut.u_asserts.fail_count, jobs_seen);
    if ((errors == 0) && (dut.u_asserts.fail_count == 0))
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

/* sim/ahb_checker.sv */
`timescale 1ns/1ps

module ahb_checker #(
  parameter logic [31:0] BASE_ADDR = 32'h4000_0000
) (
  input  logic         HCLK,
  input  logic         HRESETn,
  input  logic         HSEL,
  input  logic         HWRITE,
  input  logic [31:0]  HADDR,
  input  logic [31:0]  HWDATA,
  input  logic [2:0]   HSIZE,
  input  logic [2:0]   HBURST,
  input  logic [1:0]   HTRANS,
  input  logic         HREADYOUT,
  input  logic         HRESP,
  input  logic         job_valid,
  input  logic         job_ready,
  input  logic [127:0] job_key,
  input  logic [127:0] job_nonce,
  input  logic [127:0] job_dest,
  input  logic [127:0] job_plain_text,
  input  logic [2:0]   test_id,
  output int           errors,
  output int           jobs_seen,
  output int           pending
);

  logic [31:0]                 words [16];
  logic [31:0]                 off;
  logic [1:0]                  exp_rsp;
  logic                        dp_valid;
  logic                        dp_err;
  logic                        err_second;
  logic                        prev_active;
  logic [3:0]                  dp_idx;
  int                          err_cnt;
  int                          job_cnt;
  crypto_ahb_pkg::crypto_job_t exp_q [$];
  crypto_ahb_pkg::crypto_job_t exp_job;
  crypto_ahb_pkg::crypto_job_t got_job;

  // Expected job from the 16 mapped words, lower address in lower bits
  function automatic crypto_ahb_pkg::crypto_job_t ref_job(input logic [31:0] w [16]);
    crypto_ahb_pkg::crypto_job_t j;
    for (int i = 0; i < 4; i++)
    begin
      j.key[i*32 +: 32]        = w[i];
      j.nonce[i*32 +: 32]      = w[4 + i];
      j.dest[i*32 +: 32]       = w[8 + i];
      j.plain_text[i*32 +: 32] = w[12 + i];
    end
    return j;
  endfunction

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "single_writes";
      3'd2:    return "burst_writes";
      3'd3:    return "illegal_xfers";
      3'd4:    return "back_pressure";
      3'd5:    return "partial_update";
      default: return "reset";
    endcase
  endfunction

  task automatic mismatch(input string what, input logic [511:0] exp, input logic [511:0] act);
    $display("Fail %s %s expected %0h actual %0h", test_name(test_id), what, exp, act);
    err_cnt++;
  endtask

  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      for (int i = 0; i < 16; i++)
        words[i] = '0;
      exp_q.delete();
      dp_valid    = 1'b0;
      dp_err      = 1'b0;
      err_second  = 1'b0;
      prev_active = 1'b0;
      err_cnt     = 0;
      job_cnt     = 0;
    end
    else
    begin
      // Data phase response
      if (dp_valid && dp_err)
      begin
        exp_rsp = err_second ? 2'b11 : 2'b01;
        if ({HREADYOUT, HRESP} != exp_rsp)
          mismatch("error response {HREADYOUT,HRESP}", 512'(exp_rsp), 512'({HREADYOUT, HRESP}));
        err_second = !HREADYOUT;
      end
      else if (dp_valid && HRESP)
        mismatch("HRESP", 512'(0), 512'(1));
      else if (dp_valid && HREADYOUT)
      begin
        words[dp_idx] = HWDATA;
        if (dp_idx == 4'd15)
          exp_q.push_back(ref_job(words));
      end
      else if (!dp_valid && HRESP)
      begin
        $display("ERROR response with no transfer in progress in test %s", test_name(test_id));
        err_cnt++;
      end

      // Address phase, taken only when the bus is ready
      if (HREADYOUT)
      begin
        off      = HADDR - BASE_ADDR;
        dp_valid = HSEL && ((HTRANS == crypto_ahb_pkg::NONSEQ) ||
                            (HTRANS == crypto_ahb_pkg::SEQ) ||
                            ((HTRANS == crypto_ahb_pkg::BUSY) &&
                             (HBURST == crypto_ahb_pkg::SINGLE)));
        dp_err   = (HADDR < BASE_ADDR) || (off >= 32'h40) || (off[1:0] != 2'b00) ||
                   !HWRITE || (HSIZE != 3'b010) ||
                   ((HBURST == crypto_ahb_pkg::SINGLE) && (HTRANS != crypto_ahb_pkg::NONSEQ)) ||
                   ((HTRANS == crypto_ahb_pkg::SEQ) && !prev_active);
        dp_idx   = off[5:2];
        prev_active = HSEL && (HTRANS != crypto_ahb_pkg::IDLE);
      end

      // Job handed to the cipher core
      if (job_valid && job_ready)
      begin
        job_cnt++;
        got_job = {job_key, job_nonce, job_dest, job_plain_text};
        if (exp_q.size() == 0)
        begin
          $display("Job accepted with no finished plain text write in test %s",
                   test_name(test_id));
          err_cnt++;
        end
        else
        begin
          exp_job = exp_q.pop_front();
          if (got_job != exp_job)
            mismatch("job", exp_job, got_job);
        end
      end
    end
    errors    <= err_cnt;
    jobs_seen <= job_cnt;
    pending   <= exp_q.size();
  end

endmodule

/* sim/crypto_ahb_asserts.sv */
`timescale 1ns/1ps

module crypto_ahb_asserts (
  input logic         HCLK,
  input logic         HRESETn,
  input logic         HREADYOUT,
  input logic         HRESP,
  input logic         job_valid,
  input logic         job_ready,
  input logic [127:0] job_key,
  input logic [127:0] job_nonce,
  input logic [127:0] job_dest,
  input logic [127:0] job_plain_text
);

  int fail_count = 0;

  // First ERROR cycle waits, second one completes
  err_first: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HRESP && !HREADYOUT) |=> (HRESP && HREADYOUT))
  else
  begin
    fail_count++;
    $error("ERROR response did not complete in its second cycle");
  end

  err_second: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (HRESP && HREADYOUT) |-> $past(HRESP && !HREADYOUT))
  else
  begin
    fail_count++;
    $error("ERROR response completed without a wait cycle");
  end

  // Offered job holds still until accepted
  job_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (job_valid && !job_ready) |=> (job_valid && $stable(job_key) && $stable(job_nonce) &&
                                   $stable(job_dest) && $stable(job_plain_text)))
  else
  begin
    fail_count++;
    $error("job changed or dropped before it was accepted");
  end

  rst_ready: assert property (@(posedge HCLK) !HRESETn |-> HREADYOUT)
  else
  begin
    fail_count++;
    $error("HREADYOUT low during reset");
  end

endmodule

bind crypto_ahb_slave crypto_ahb_asserts u_asserts (
  .HCLK           (HCLK),
  .HRESETn        (HRESETn),
  .HREADYOUT      (HREADYOUT),
  .HRESP          (HRESP),
  .job_valid      (job_valid),
  .job_ready      (job_ready),
  .job_key        (job_key),
  .job_nonce      (job_nonce),
  .job_dest       (job_dest),
  .job_plain_text (job_plain_text)
);

/* hw/crypto_ahb_slave.sv */
`timescale 1ns/1ps

module crypto_ahb_slave #(
  parameter logic [crypto_ahb_pkg::ADDR_W-1:0] BASE_ADDR = 32'h4000_0000
) (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  // AHB-Lite slave side
  input  logic                               HSEL,
  input  logic [crypto_ahb_pkg::ADDR_W-1:0]  HADDR,
  input  logic                               HWRITE,
  input  logic [2:0]                         HSIZE,
  input  logic [2:0]                         HBURST,
  input  logic [1:0]                         HTRANS,
  input  logic [crypto_ahb_pkg::WORD_W-1:0]  HWDATA,
  input  logic                               HREADY,
  output logic                               HREADYOUT,
  output logic                               HRESP,
  // Job port to the cipher core
  output logic                               job_valid,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_key,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_nonce,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_dest,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_plain_text,
  input  logic                               job_ready
);

  ahb_wr_if     wr_cmd ();
  crypto_job_if job_q ();

  ahb_addr_decode #(
    .BASE_ADDR (BASE_ADDR)
  ) u_decode (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .HSEL    (HSEL),
    .HADDR   (HADDR),
    .HWRITE  (HWRITE),
    .HSIZE   (HSIZE),
    .HBURST  (crypto_ahb_pkg::hburst_e'(HBURST)),
    .HTRANS  (crypto_ahb_pkg::htrans_e'(HTRANS)),
    .HREADY  (HREADY),
    .cmd     (wr_cmd.decode)
  );

  reg_write_exec u_exec (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HWDATA    (HWDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .cmd       (wr_cmd.execute),
    .job       (job_q.source)
  );

  job_buffer u_buffer (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .job_ready      (job_ready),
    .job            (job_q.sink),
    .job_valid      (job_valid),
    .job_key        (job_key),
    .job_nonce      (job_nonce),
    .job_dest       (job_dest),
    .job_plain_text (job_plain_text)
  );

endmodule

/* hw/job_buffer.sv */
`timescale 1ns/1ps

module job_buffer (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic                               job_ready,
  crypto_job_if.sink                         job,
  output logic                               job_valid,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_key,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_nonce,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_dest,
  output logic [crypto_ahb_pkg::BLOCK_W-1:0] job_plain_text
);

  crypto_ahb_pkg::buf_state_e  state;
  crypto_ahb_pkg::crypto_job_t held;
  logic                        take;

  // Room now, or the held job leaves this cycle
  assign job.ready = (state == crypto_ahb_pkg::BUF_EMPTY) || job_ready;
  assign take      = job.valid && job.ready;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state <= crypto_ahb_pkg::BUF_EMPTY;
      held  <= '0;
    end
    else
    begin
      if (take)
      begin
        state <= crypto_ahb_pkg::BUF_FULL;
        held  <= job.job;
      end
      else if ((state == crypto_ahb_pkg::BUF_FULL) && job_ready)
      begin
        state <= crypto_ahb_pkg::BUF_EMPTY;
      end
    end
  end

  assign job_valid      = (state == crypto_ahb_pkg::BUF_FULL);
  assign job_key        = held.key;
  assign job_nonce      = held.nonce;
  assign job_dest       = held.dest;
  assign job_plain_text = held.plain_text;

endmodule

/* hw/reg_write_exec.sv */
`timescale 1ns/1ps

module reg_write_exec (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic [crypto_ahb_pkg::WORD_W-1:0] HWDATA,
  output logic                              HREADYOUT,
  output logic                              HRESP,
  ahb_wr_if.execute                         cmd,
  crypto_job_if.source                      job
);

  logic [crypto_ahb_pkg::BLOCK_W-1:0] key_q;
  logic [crypto_ahb_pkg::BLOCK_W-1:0] nonce_q;
  logic [crypto_ahb_pkg::BLOCK_W-1:0] dest_q;
  logic [crypto_ahb_pkg::BLOCK_W-1:0] pt_q;
  logic [crypto_ahb_pkg::BLOCK_W-1:0] key_d;
  logic [crypto_ahb_pkg::BLOCK_W-1:0] nonce_d;
  logic [crypto_ahb_pkg::BLOCK_W-1:0] dest_d;
  logic [crypto_ahb_pkg::BLOCK_W-1:0] pt_d;
  crypto_ahb_pkg::resp_state_e        resp_state;
  crypto_ahb_pkg::resp_state_e        resp_phase;
  logic                               write_ok;
  logic                               last_pt;
  logic                               stall;
  logic                               commit;

  function automatic logic [crypto_ahb_pkg::BLOCK_W-1:0] put_word(
    input logic [crypto_ahb_pkg::BLOCK_W-1:0]    blk,
    input logic [crypto_ahb_pkg::WORD_IDX_W-1:0] idx,
    input logic [crypto_ahb_pkg::WORD_W-1:0]     data
  );
    logic [crypto_ahb_pkg::BLOCK_W-1:0] res;
    res = blk;
    res[idx * crypto_ahb_pkg::WORD_W +: crypto_ahb_pkg::WORD_W] = data;
    return res;
  endfunction

  // An error command seen in OKAY is the first error cycle
  always_comb
  begin
    resp_phase = resp_state;
    if ((resp_state == crypto_ahb_pkg::RESP_OKAY) && cmd.cmd_valid && cmd.cmd_err)
    begin
      resp_phase = crypto_ahb_pkg::RESP_ERR1;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      resp_state <= crypto_ahb_pkg::RESP_OKAY;
    end
    else if (resp_phase == crypto_ahb_pkg::RESP_ERR1)
    begin
      resp_state <= crypto_ahb_pkg::RESP_ERR2;
    end
    else
    begin
      resp_state <= crypto_ahb_pkg::RESP_OKAY;
    end
  end

  assign write_ok = (resp_phase == crypto_ahb_pkg::RESP_OKAY) && cmd.cmd_valid && !cmd.cmd_err;
  assign last_pt  = (cmd.cmd_field == crypto_ahb_pkg::FIELD_PT) &&
                    (cmd.cmd_word == crypto_ahb_pkg::LAST_WORD);

  // Final word waits until the job can be handed over
  assign stall  = write_ok && last_pt && !job.ready;
  assign commit = write_ok && !stall;

  always_comb
  begin
    unique case (resp_phase)
      crypto_ahb_pkg::RESP_ERR1: HREADYOUT = 1'b0;
      crypto_ahb_pkg::RESP_ERR2: HREADYOUT = 1'b1;
      default:                   HREADYOUT = !stall;
    endcase
  end

  assign HRESP = (resp_phase != crypto_ahb_pkg::RESP_OKAY);

  // Fields with the data-phase word merged in
  always_comb
  begin
    key_d   = key_q;
    nonce_d = nonce_q;
    dest_d  = dest_q;
    pt_d    = pt_q;
    unique case (cmd.cmd_field)
      crypto_ahb_pkg::FIELD_KEY:   key_d   = put_word(key_q, cmd.cmd_word, HWDATA);
      crypto_ahb_pkg::FIELD_NONCE: nonce_d = put_word(nonce_q, cmd.cmd_word, HWDATA);
      crypto_ahb_pkg::FIELD_DEST:  dest_d  = put_word(dest_q, cmd.cmd_word, HWDATA);
      default:                     pt_d    = put_word(pt_q, cmd.cmd_word, HWDATA);
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      key_q   <= '0;
      nonce_q <= '0;
      dest_q  <= '0;
      pt_q    <= '0;
    end
    else if (commit)
    begin
      key_q   <= key_d;
      nonce_q <= nonce_d;
      dest_q  <= dest_d;
      pt_q    <= pt_d;
    end
  end

  // Job offered for the whole data phase of the final word
  assign job.valid          = write_ok && last_pt;
  assign job.job.key        = key_d;
  assign job.job.nonce      = nonce_d;
  assign job.job.dest       = dest_d;
  assign job.job.plain_text = pt_d;

endmodule

/* hw/ahb_addr_decode.sv */
`timescale 1ns/1ps

module ahb_addr_decode #(
  parameter logic [crypto_ahb_pkg::ADDR_W-1:0] BASE_ADDR = 32'h4000_0000
) (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic                              HSEL,
  input  logic [crypto_ahb_pkg::ADDR_W-1:0] HADDR,
  input  logic                              HWRITE,
  input  logic [2:0]                        HSIZE,
  input  crypto_ahb_pkg::hburst_e           HBURST,
  input  crypto_ahb_pkg::htrans_e           HTRANS,
  input  logic                              HREADY,
  ahb_wr_if.decode                          cmd
);

  logic [crypto_ahb_pkg::ADDR_W-1:0] offset;
  logic                              in_map;
  logic                              active;
  logic                              prev_active;
  logic                              bad_type;
  logic                              bad_xfer;
  crypto_ahb_pkg::reg_field_e        addr_field;

  assign offset = HADDR - BASE_ADDR;

  // Word aligned and inside the 16-word window
  assign in_map = (HADDR >= BASE_ADDR) &&
                  (offset < crypto_ahb_pkg::ADDR_W'(crypto_ahb_pkg::MAP_BYTES)) &&
                  (offset[1:0] == 2'b00);

  // BUSY in a SINGLE burst is treated as a transfer so it can be rejected
  assign active = HSEL && ((HTRANS == crypto_ahb_pkg::NONSEQ) ||
                           (HTRANS == crypto_ahb_pkg::SEQ) ||
                           ((HTRANS == crypto_ahb_pkg::BUSY) &&
                            (HBURST == crypto_ahb_pkg::SINGLE)));

  // Burst and transfer type legality
  assign bad_type = ((HBURST == crypto_ahb_pkg::SINGLE) &&
                     ((HTRANS == crypto_ahb_pkg::BUSY) || (HTRANS == crypto_ahb_pkg::SEQ))) ||
                    ((HTRANS == crypto_ahb_pkg::SEQ) && !prev_active);

  assign bad_xfer = !in_map || !HWRITE || (HSIZE != crypto_ahb_pkg::HSIZE_WORD) || bad_type;

  // Find the field whose offset window holds the address
  always_comb
  begin
    addr_field = crypto_ahb_pkg::FIELD_KEY;
    for (int f = 0; f < 4; f++)
    begin
      if (offset[5:4] == crypto_ahb_pkg::FIELD_OFFSETS[f][5:4])
      begin
        addr_field = crypto_ahb_pkg::reg_field_e'(2'(f));
      end
    end
  end

  // Control part of the command, held while HREADY is low
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      cmd.cmd_valid <= 1'b0;
      cmd.cmd_err   <= 1'b0;
      prev_active   <= 1'b0;
    end
    else if (HREADY)
    begin
      cmd.cmd_valid <= active;
      cmd.cmd_err   <= active && bad_xfer;
      prev_active   <= HSEL && (HTRANS != crypto_ahb_pkg::IDLE);
    end
  end

  // Target location
  always_ff @(posedge HCLK)
  begin
    if (HREADY)
    begin
      cmd.cmd_field <= addr_field;
      cmd.cmd_word  <= offset[3:2];
    end
  end

endmodule

/* hw/crypto_job_if.sv */
`timescale 1ns/1ps

interface crypto_job_if;

  // Offered job, stable while valid is high without ready
  logic                        valid;
  logic                        ready;
  crypto_ahb_pkg::crypto_job_t job;

  // Register write stage offers the job
  modport source (
    output valid, job,
    input  ready
  );

  // Holding buffer takes the job
  modport sink (
    input  valid, job,
    output ready
  );

endinterface

/* hw/ahb_wr_if.sv */
`timescale 1ns/1ps

interface ahb_wr_if;

  // Data phase belongs to an active transfer
  logic                                   cmd_valid;
  // Field and word targeted by the transfer
  crypto_ahb_pkg::reg_field_e             cmd_field;
  logic [crypto_ahb_pkg::WORD_IDX_W-1:0]  cmd_word;
  // Transfer must be answered with ERROR
  logic                                   cmd_err;

  modport decode (
    output cmd_valid, cmd_field, cmd_word, cmd_err
  );

  modport execute (
    input cmd_valid, cmd_field, cmd_word, cmd_err
  );

endinterface

/* hw/crypto_ahb_pkg.sv */
package crypto_ahb_pkg;

  // Bus and field widths
  localparam int ADDR_W          = 32;
  localparam int WORD_W          = 32;
  localparam int BLOCK_W         = 128;
  localparam int WORDS_PER_FIELD = BLOCK_W / WORD_W;
  localparam int WORD_IDX_W      = $clog2(WORDS_PER_FIELD);

  // Index of the word that completes a field
  localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(WORDS_PER_FIELD - 1);

  // Byte offsets of the four fields from the base address
  localparam logic [3:0][7:0] FIELD_OFFSETS = {8'h30, 8'h20, 8'h10, 8'h00};

  // Total mapped bytes, 16 words
  localparam int unsigned MAP_BYTES = 4 * WORDS_PER_FIELD * (WORD_W / 8);

  // Only 32-bit transfers are accepted
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  typedef enum logic [1:0] {IDLE, BUSY, NONSEQ, SEQ} htrans_e;

  typedef enum logic [2:0] {
    SINGLE, INCR, WRAP4, INCR4, WRAP8, INCR8, WRAP16, INCR16
  } hburst_e;

  typedef enum logic [1:0] {FIELD_KEY, FIELD_NONCE, FIELD_DEST, FIELD_PT} reg_field_e;

  typedef enum logic [1:0] {RESP_OKAY, RESP_ERR1, RESP_ERR2} resp_state_e;

  typedef enum logic {BUF_EMPTY, BUF_FULL} buf_state_e;

  typedef struct packed {
    logic [BLOCK_W-1:0] key;
    logic [BLOCK_W-1:0] nonce;
    logic [BLOCK_W-1:0] dest;
    logic [BLOCK_W-1:0] plain_text;
  } crypto_job_t;

endpackage
